/* hdl/realign_pkg.sv */
package realign_pkg;

   localparam int AXI_SIZE_W = 3;

   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

   // transaction states of burst_ctrl
   typedef enum logic [2:0] {
      B_IDLE,
      B_ADDR,
      B_DATA,
      B_RESP,
      B_DONE
   } burst_state_t;

   // W channel sequencer states
   typedef enum logic [1:0] {
      W_IDLE,
      W_BEAT,
      W_FLUSH
   } beat_state_t;

   // byte offset bits inside one data word
   function automatic int calc_offset_w(input int data_w);
      return $clog2(data_w / 8);
   endfunction

endpackage

/* hdl/burst_split.sv */
`timescale 1ns/1ps

module burst_split import realign_pkg::*; #(
   parameter int DATA_W = 32,
   localparam int OFFSET_W = calc_offset_w(DATA_W)
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [OFFSET_W-1:0] offset_i,
   input  logic [DATA_W-1:0]   data_in_i,
   input  logic                data_valid_i,
   output logic [DATA_W-1:0]   data_out_o
);

   localparam int CAT_W = 2 * DATA_W - 8;

   logic [DATA_W-9:0] stored_q;   // upper bytes of last taken word
   logic [CAT_W-1:0]  joined;
   int                base;

   always_ff @(posedge clk_i) begin
      if (data_valid_i) begin
         stored_q <= data_in_i[DATA_W-1:8];
      end
   end

   // current word above the held bytes, window slides down with offset
   assign joined = {data_in_i, stored_q};

   always_comb begin
      base       = (DATA_W - 8) - 8 * int'(offset_i);
      data_out_o = joined[base +: DATA_W];
   end

   a_zero_offset_pass : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (offset_i == '0) |-> (data_out_o == data_in_i)
   );

endmodule

/* hdl/burst_ctrl.sv */
`timescale 1ns/1ps

module burst_ctrl import realign_pkg::*; #(
   parameter int DATA_W   = 32,
   parameter int ADDR_W   = 32,
   parameter int NBYTES_W = 11,
   localparam int BYTES    = DATA_W / 8,
   localparam int OFFSET_W = calc_offset_w(DATA_W)
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  logic [ADDR_W-1:0]     addr_i,
   input  logic [NBYTES_W-1:0]   nbytes_i,
   output logic                  ack_o,
   output logic                  err_o,
   output logic [ADDR_W-1:0]     awaddr_o,
   output logic [7:0]            awlen_o,
   output logic [AXI_SIZE_W-1:0] awsize_o,
   output logic [1:0]            awburst_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   input  logic [1:0]            bresp_i,
   input  logic                  bvalid_i,
   output logic                  bready_o,
   output logic                  w_start_o,
   output logic [8:0]            beat_cnt_o,
   output logic [BYTES-1:0]      first_strb_o,
   output logic [BYTES-1:0]      last_strb_o,
   output logic                  flush_o,
   output logic [OFFSET_W-1:0]   offset_o,
   input  logic                  w_done_i
);

   localparam int SPAN_W = NBYTES_W + 1;

   burst_state_t        state_q;
   logic [ADDR_W-1:0]   addr_q;
   logic [8:0]          beats_q;
   logic [BYTES-1:0]    first_strb_q;
   logic [BYTES-1:0]    last_strb_q;
   logic                flush_q;
   logic [OFFSET_W-1:0] offset_q;
   logic                w_start_q;
   logic                err_q;
   logic                accept;
   logic [OFFSET_W-1:0] offset;
   logic [SPAN_W-1:0]   span;     // offset + nbytes
   logic [SPAN_W-1:0]   beats;
   logic [SPAN_W-1:0]   words;
   logic [OFFSET_W-1:0] end_lane;

   assign accept   = (state_q == B_IDLE) && req_i;
   assign offset   = addr_i[OFFSET_W-1:0];
   assign span     = SPAN_W'(offset) + SPAN_W'(nbytes_i);
   assign beats    = (span + SPAN_W'(BYTES - 1)) >> OFFSET_W;
   assign words    = (SPAN_W'(nbytes_i) + SPAN_W'(BYTES - 1)) >> OFFSET_W;
   assign end_lane = span[OFFSET_W-1:0];

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q       <= {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
         offset_q     <= offset;
         beats_q      <= beats[8:0];
         first_strb_q <= {BYTES{1'b1}} << offset;
         last_strb_q  <= (end_lane == '0) ? {BYTES{1'b1}} : ~({BYTES{1'b1}} << end_lane);
         flush_q      <= beats > words;   // shifted tail spills into one more beat
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q   <= B_IDLE;
         w_start_q <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         w_start_q <= 1'b0;
         case (state_q)
            B_IDLE: if (req_i) state_q <= B_ADDR;
            B_ADDR: if (awready_i) begin
               state_q   <= B_DATA;
               w_start_q <= 1'b1;
            end
            B_DATA: if (w_done_i) state_q <= B_RESP;
            B_RESP: if (bvalid_i) begin
               err_q   <= (bresp_i != AXI_RESP_OKAY);
               state_q <= B_DONE;
            end
            B_DONE: if (!req_i) state_q <= B_IDLE;   // four-phase return
            default: state_q <= B_IDLE;
         endcase
      end
   end

   assign awaddr_o     = addr_q;
   assign awlen_o      = 8'(beats_q - 9'd1);
   assign awsize_o     = AXI_SIZE_W'(OFFSET_W);
   assign awburst_o    = AXI_BURST_INCR;
   assign awvalid_o    = (state_q == B_ADDR);
   assign bready_o     = (state_q == B_RESP);
   assign ack_o        = (state_q == B_DONE);
   assign err_o        = err_q;
   assign w_start_o    = w_start_q;
   assign beat_cnt_o   = beats_q;
   assign first_strb_o = first_strb_q;
   assign last_strb_o  = last_strb_q;
   assign flush_o      = flush_q;
   assign offset_o     = offset_q;

   a_nbytes_nonzero : assert property (
      @(posedge clk_i) disable iff (rst_i) accept |-> (nbytes_i != '0)
   );
   a_max_256_beats : assert property (
      @(posedge clk_i) disable iff (rst_i) accept |-> (beats <= SPAN_W'(256))
   );
   a_no_4k_cross : assert property (
      @(posedge clk_i) disable iff (rst_i)
      accept |-> (int'(addr_i[11:0]) + int'(nbytes_i) <= 4096)
   );

endmodule

/* hdl/w_beat_ctrl.sv */
`timescale 1ns/1ps

module w_beat_ctrl import realign_pkg::*; #(
   parameter int DATA_W = 32,
   localparam int BYTES = DATA_W / 8
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              w_start_i,
   input  logic [8:0]        beat_cnt_i,
   input  logic [BYTES-1:0]  first_strb_i,
   input  logic [BYTES-1:0]  last_strb_i,
   input  logic              flush_i,
   input  logic              data_valid_i,
   output logic              data_ready_o,
   output logic              word_take_o,
   input  logic [DATA_W-1:0] wdata_i,
   output logic [DATA_W-1:0] wdata_o,
   output logic [BYTES-1:0]  wstrb_o,
   output logic              wlast_o,
   output logic              wvalid_o,
   input  logic              wready_i,
   output logic              w_done_o
);

   beat_state_t state_q;
   logic [8:0]  rem_q;      // beats still to send
   logic        first_q;
   logic        last_beat;
   logic        beat_acc;

   assign last_beat = (rem_q == 9'd1);

   always_comb begin
      wvalid_o     = 1'b0;
      data_ready_o = 1'b0;
      case (state_q)
         W_BEAT: begin
            wvalid_o     = data_valid_i;
            data_ready_o = wready_i;   // a word moves only with its W beat
         end
         W_FLUSH: wvalid_o = 1'b1;   // held bytes only, no source word
         default: ;
      endcase
   end

   assign beat_acc    = wvalid_o && wready_i;
   assign word_take_o = beat_acc && (state_q == W_BEAT);
   assign wlast_o     = last_beat && ((state_q == W_FLUSH) ||
                                      ((state_q == W_BEAT) && data_valid_i));
   assign w_done_o    = beat_acc && wlast_o;
   assign wdata_o     = wdata_i;

   always_comb begin
      wstrb_o = {BYTES{1'b1}};
      if (first_q) begin
         wstrb_o = wstrb_o & first_strb_i;
      end
      if (last_beat) begin
         wstrb_o = wstrb_o & last_strb_i;   // single beat gets both masks
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= W_IDLE;
         rem_q   <= '0;
         first_q <= 1'b0;
      end else begin
         case (state_q)
            W_IDLE: if (w_start_i) begin
               rem_q   <= beat_cnt_i;
               first_q <= 1'b1;
               state_q <= W_BEAT;
            end
            W_BEAT: if (beat_acc) begin
               rem_q   <= rem_q - 9'd1;
               first_q <= 1'b0;
               if (last_beat) begin
                  state_q <= W_IDLE;
               end else if (flush_i && rem_q == 9'd2) begin
                  state_q <= W_FLUSH;
               end
            end
            W_FLUSH: if (beat_acc) begin
               rem_q   <= rem_q - 9'd1;
               state_q <= W_IDLE;
            end
            default: state_q <= W_IDLE;
         endcase
      end
   end

   a_wlast_with_wvalid : assert property (
      @(posedge clk_i) disable iff (rst_i) wlast_o |-> wvalid_o
   );
   a_start_when_idle : assert property (
      @(posedge clk_i) disable iff (rst_i) w_start_i |-> (state_q == W_IDLE)
   );

endmodule

/* hdl/unaligned_writer.sv */
`timescale 1ns/1ps

module unaligned_writer import realign_pkg::*; #(
   parameter int DATA_W   = 32,
   parameter int ADDR_W   = 32,
   parameter int NBYTES_W = 11,
   localparam int BYTES    = DATA_W / 8,
   localparam int OFFSET_W = calc_offset_w(DATA_W)
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // client command
   input  logic                  req_i,
   input  logic [ADDR_W-1:0]     addr_i,
   input  logic [NBYTES_W-1:0]   nbytes_i,
   output logic                  ack_o,
   output logic                  err_o,
   // payload stream
   input  logic [DATA_W-1:0]     data_i,
   input  logic                  data_valid_i,
   output logic                  data_ready_o,
   // AXI4 write master
   output logic [ADDR_W-1:0]     awaddr_o,
   output logic [7:0]            awlen_o,
   output logic [AXI_SIZE_W-1:0] awsize_o,
   output logic [1:0]            awburst_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output logic [DATA_W-1:0]     wdata_o,
   output logic [BYTES-1:0]      wstrb_o,
   output logic                  wlast_o,
   output logic                  wvalid_o,
   input  logic                  wready_i,
   input  logic [1:0]            bresp_i,
   input  logic                  bvalid_i,
   output logic                  bready_o
);

   logic                w_start;
   logic [8:0]          beat_cnt;
   logic [BYTES-1:0]    first_strb;
   logic [BYTES-1:0]    last_strb;
   logic                flush;
   logic [OFFSET_W-1:0] offset;
   logic                w_done;
   logic                word_take;
   logic [DATA_W-1:0]   split_data;   // payload moved to target lanes

   burst_ctrl #(
      .DATA_W   (DATA_W),
      .ADDR_W   (ADDR_W),
      .NBYTES_W (NBYTES_W)
   ) i_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .nbytes_i     (nbytes_i),
      .ack_o        (ack_o),
      .err_o        (err_o),
      .awaddr_o     (awaddr_o),
      .awlen_o      (awlen_o),
      .awsize_o     (awsize_o),
      .awburst_o    (awburst_o),
      .awvalid_o    (awvalid_o),
      .awready_i    (awready_i),
      .bresp_i      (bresp_i),
      .bvalid_i     (bvalid_i),
      .bready_o     (bready_o),
      .w_start_o    (w_start),
      .beat_cnt_o   (beat_cnt),
      .first_strb_o (first_strb),
      .last_strb_o  (last_strb),
      .flush_o      (flush),
      .offset_o     (offset),
      .w_done_i     (w_done)
   );

   w_beat_ctrl #(
      .DATA_W (DATA_W)
   ) i_wbeat (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .w_start_i    (w_start),
      .beat_cnt_i   (beat_cnt),
      .first_strb_i (first_strb),
      .last_strb_i  (last_strb),
      .flush_i      (flush),
      .data_valid_i (data_valid_i),
      .data_ready_o (data_ready_o),
      .word_take_o  (word_take),
      .wdata_i      (split_data),
      .wdata_o      (wdata_o),
      .wstrb_o      (wstrb_o),
      .wlast_o      (wlast_o),
      .wvalid_o     (wvalid_o),
      .wready_i     (wready_i),
      .w_done_o     (w_done)
   );

   burst_split #(
      .DATA_W (DATA_W)
   ) i_split (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .offset_i     (offset),
      .data_in_i    (data_i),
      .data_valid_i (word_take),
      .data_out_o   (split_data)
   );

endmodule

/* bench/tb_unaligned_writer.sv */
`timescale 1ns/1ps

module tb_unaligned_writer;

   localparam int DATA_W      = 32;
   localparam int ADDR_W      = 32;
   localparam int NBYTES_W    = 11;
   localparam int MEM_SIZE    = 256;
   localparam int TIMEOUT_CYC = 20000;   // ~45 transfers under 150 cycles each, plus margin

   logic                clk_i = 1'b0;
   logic                rst_i;
   logic                req_i;
   logic [ADDR_W-1:0]   addr_i;
   logic [NBYTES_W-1:0] nbytes_i;
   logic                ack_o;
   logic                err_o;
   logic [DATA_W-1:0]   data_i;
   logic                data_valid_i;
   logic                data_ready_o;
   logic [ADDR_W-1:0]   awaddr_o;
   logic [7:0]          awlen_o;
   logic [2:0]          awsize_o;
   logic [1:0]          awburst_o;
   logic                awvalid_o;
   logic                awready_i;
   logic [DATA_W-1:0]   wdata_o;
   logic [3:0]          wstrb_o;
   logic                wlast_o;
   logic                wvalid_o;
   logic                wready_i;
   logic [1:0]          bresp_i;
   logic                bvalid_i;
   logic                bready_o;

   logic [7:0]  mem [MEM_SIZE];       // slave memory
   logic [7:0]  exp_mem [MEM_SIZE];
   logic [7:0]  ref_mem [MEM_SIZE];
   logic [7:0]  payload [1024];
   logic [31:0] rng_state = 32'd20380;
   logic        stall_en = 1'b0;
   logic [1:0]  resp_cfg = 2'b00;
   logic [31:0] exp_awaddr;
   logic [7:0]  exp_awlen;
   logic [31:0] aw_base;
   int          beat_idx = 0;
   int          err_cnt = 0;
   int          test_cnt = 0;
   int          fail_cnt = 0;
   int          cyc_cnt = 0;

   unaligned_writer #(
      .DATA_W   (DATA_W),
      .ADDR_W   (ADDR_W),
      .NBYTES_W (NBYTES_W)
   ) i_dut (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .nbytes_i     (nbytes_i),
      .ack_o        (ack_o),
      .err_o        (err_o),
      .data_i       (data_i),
      .data_valid_i (data_valid_i),
      .data_ready_o (data_ready_o),
      .awaddr_o     (awaddr_o),
      .awlen_o      (awlen_o),
      .awsize_o     (awsize_o),
      .awburst_o    (awburst_o),
      .awvalid_o    (awvalid_o),
      .awready_i    (awready_i),
      .wdata_o      (wdata_o),
      .wstrb_o      (wstrb_o),
      .wlast_o      (wlast_o),
      .wvalid_o     (wvalid_o),
      .wready_i     (wready_i),
      .bresp_i      (bresp_i),
      .bvalid_i     (bvalid_i),
      .bready_o     (bready_o)
   );

   always #2 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   function automatic void init_mem();
      for (int i = 0; i < MEM_SIZE; i++) begin
         mem[i]     = 8'(i) ^ 8'hA5;
         exp_mem[i] = 8'(i) ^ 8'hA5;
      end
   endfunction

   always @(posedge clk_i) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= TIMEOUT_CYC) begin
         $display("timeout: transfers did not complete within %0d cycles", TIMEOUT_CYC);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // AXI slave with byte memory
   always @(posedge clk_i) begin : slave_model
      logic [31:0] r;
      logic [7:0]  waddr;
      r = next_rand();
      awready_i <= stall_en ? r[0] : 1'b1;
      wready_i  <= stall_en ? (r[2:1] != 2'b00) : 1'b1;
      if (awvalid_o && awready_i) begin
         compare("awaddr_o", awaddr_o, exp_awaddr);
         compare("awlen_o", awlen_o, exp_awlen);
         compare("awsize_o", awsize_o, 2);
         compare("awburst_o", awburst_o, 1);
         aw_base  = awaddr_o;
         beat_idx = 0;
      end
      if (wvalid_o && wready_i) begin
         for (int l = 0; l < DATA_W / 8; l++) begin
            waddr = aw_base[7:0] + 8'(DATA_W / 8 * beat_idx + l);
            if (wstrb_o[l]) begin
               mem[waddr] = wdata_o[8*l +: 8];
            end
         end
         compare("wlast_o", wlast_o, beat_idx == int'(exp_awlen));
         beat_idx++;
         if (wlast_o) begin
            bvalid_i <= 1'b1;
            bresp_i  <= resp_cfg;
         end
      end
      if (bvalid_i && bready_o) begin
         bvalid_i <= 1'b0;
      end
   end

   task automatic run_transfer(input int addr, input int n, input logic [31:0] seed,
                               input logic stall, input logic [1:0] resp, input int hold);
      logic [31:0] s;
      int          words;
      s     = seed;
      words = (n + 3) / 4;
      for (int i = 0; i < 4 * words; i++) begin
         s          = xorshift32(s);
         payload[i] = s[7:0];
      end
      for (int i = 0; i < n; i++) begin
         exp_mem[(addr + i) % MEM_SIZE] = payload[i];
      end
      stall_en   = stall;
      resp_cfg   = resp;
      exp_awaddr = 32'(addr) & ~32'h3;
      exp_awlen  = 8'((addr % 4 + n + 3) / 4 - 1);
      fork
         begin
            @(posedge clk_i);
            req_i    <= 1'b1;
            addr_i   <= 32'(addr);
            nbytes_i <= NBYTES_W'(n);
            do @(posedge clk_i); while (!ack_o);
            compare("err_o", err_o, resp != 2'b00);
            compare("W beat count", beat_idx, 32'(exp_awlen) + 1);
            repeat (hold) begin
               @(posedge clk_i);
               compare("ack_o", ack_o, 1'b1);
            end
            req_i <= 1'b0;
            @(posedge clk_i);
            compare("ack_o", ack_o, 1'b1);   // low req not seen yet
            @(posedge clk_i);
            compare("ack_o", ack_o, 1'b0);
            repeat (3) begin
               @(posedge clk_i);
               compare("awvalid_o", awvalid_o, 1'b0);
            end
         end
         begin
            @(posedge clk_i);
            for (int w = 0; w < words; w++) begin
               if (stall) begin
                  data_valid_i <= 1'b0;
                  repeat (next_rand() % 3) @(posedge clk_i);
               end
               data_i <= {payload[4*w+3], payload[4*w+2], payload[4*w+1], payload[4*w]};
               data_valid_i <= 1'b1;
               do @(posedge clk_i); while (!data_ready_o);
            end
            data_valid_i <= 1'b0;
         end
      join
      stall_en = 1'b0;
      for (int i = 0; i < MEM_SIZE; i++) begin
         compare($sformatf("mem[0x%02h]", i), mem[i], exp_mem[i]);
      end
   endtask

   task automatic report_result(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d errors", name, err_cnt - errs_before);
      end
   endtask

   task automatic aligned_transfers();
      int e;
      e = err_cnt;
      run_transfer(8'h10, 16, next_rand(), 1'b0, 2'b00, 1);
      run_transfer(8'h24, 7, next_rand(), 1'b0, 2'b00, 1);
      run_transfer(8'h30, 1, next_rand(), 1'b0, 2'b00, 1);
      run_transfer(8'h38, 4, next_rand(), 1'b0, 2'b00, 1);
      run_transfer(8'h40, 33, next_rand(), 1'b0, 2'b00, 1);
      report_result("aligned", e);
   endtask

   task automatic offset_sweep();
      int e;
      int lens [5] = '{1, 3, 4, 5, 13};
      e = err_cnt;
      for (int off = 1; off < 4; off++) begin
         for (int li = 0; li < 5; li++) begin
            run_transfer(8'h40 + 16 * li + off, lens[li], next_rand(), 1'b0, 2'b00, 1);
         end
      end
      report_result("offset sweep", e);
   endtask

   task automatic geometry_checks();
      int e;
      e = err_cnt;
      run_transfer(8'h07, 1, next_rand(), 1'b0, 2'b00, 1);     // single beat, both masks
      run_transfer(8'h0B, 2, next_rand(), 1'b0, 2'b00, 1);     // flush on two beats
      run_transfer(8'h05, 64, next_rand(), 1'b0, 2'b00, 1);
      run_transfer(8'h82, 100, next_rand(), 1'b0, 2'b00, 1);
      report_result("geometry", e);
   endtask

   task automatic stall_equivalence();
      int          e;
      int          addrs [6];
      int          lens [6];
      logic [31:0] seeds [6];
      e = err_cnt;
      for (int k = 0; k < 6; k++) begin
         addrs[k] = next_rand() % 128;
         lens[k]  = 1 + next_rand() % 48;
         seeds[k] = next_rand();
      end
      init_mem();
      for (int k = 0; k < 6; k++) begin
         run_transfer(addrs[k], lens[k], seeds[k], 1'b0, 2'b00, 1);
      end
      for (int i = 0; i < MEM_SIZE; i++) begin
         ref_mem[i] = mem[i];
      end
      init_mem();
      for (int k = 0; k < 6; k++) begin
         run_transfer(addrs[k], lens[k], seeds[k], 1'b1, 2'b00, 1);
      end
      for (int i = 0; i < MEM_SIZE; i++) begin
         compare($sformatf("stalled mem[0x%02h]", i), mem[i], ref_mem[i]);
      end
      report_result("stalls", e);
   endtask

   task automatic slave_error();
      int e;
      e = err_cnt;
      run_transfer(8'h61, 9, next_rand(), 1'b0, 2'b10, 2);   // SLVERR
      run_transfer(8'h70, 6, next_rand(), 1'b0, 2'b00, 1);
      report_result("slave error", e);
   endtask

   task automatic handshake_hold();
      int e;
      e = err_cnt;
      run_transfer(8'hA1, 10, next_rand(), 1'b0, 2'b00, 1 + next_rand() % 12);
      run_transfer(8'hB6, 10, next_rand(), 1'b0, 2'b00, 1 + next_rand() % 12);
      run_transfer(8'hC0, 10, next_rand(), 1'b0, 2'b00, 1 + next_rand() % 12);
      report_result("four-phase", e);
   endtask

   initial begin
      rst_i        = 1'b1;
      req_i        = 1'b0;
      addr_i       = '0;
      nbytes_i     = '0;
      data_i       = '0;
      data_valid_i = 1'b0;
      awready_i    = 1'b0;
      wready_i     = 1'b0;
      bresp_i      = 2'b00;
      bvalid_i     = 1'b0;
      init_mem();
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      aligned_transfers();
      offset_sweep();
      geometry_checks();
      stall_equivalence();
      slave_error();
      handshake_hold();
      $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* flist.f */
hdl/realign_pkg.sv
hdl/burst_split.sv
hdl/burst_ctrl.sv
hdl/w_beat_ctrl.sv
hdl/unaligned_writer.sv
bench/tb_unaligned_writer.sv
